// ==== Makefile ====
# Verilator build and run of the pe testbench

SIM = obj_dir/Vpe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module pe_tb -f compile.f

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== compile.f ====
source/pe_pkg.sv
source/lane_ctrl_if.sv
source/pe_decode.sv
source/pe_operand_stage.sv
source/pe_lane.sv
source/pe_lane_array.sv
source/pe_top.sv
sim/pe_tb.sv

// ==== sim/pe_tb.sv ====
`timescale 1ns/1ns

module pe_tb;

    import pe_pkg::*;

    localparam int clk_period  = 8;
    localparam int burst_len   = 40;  // instructions per test
    localparam int test_count  = 7;
    localparam int flush_tag   = test_count;  // bubbles between tests
    localparam int watchdog_ns = test_count * burst_len * clk_period
                               + (test_count + 2) * (pe_latency + 2) * clk_period + 200;

    // one expected output word, tagged with the test that issued it
    typedef struct packed {
        logic [data_width-1:0] res;
        logic                  valid;
        logic                  load;   // opcode 000 or 100
        int                    test;
    } exp_t;

    bit                    clk;        // 2-state, no x to 0 edge at time 0
    logic                  rst;
    logic [inst_width-1:0] inst;
    logic [data_width-1:0] din_pe;
    logic [data_width-1:0] din_wb;
    logic [data_width-1:0] result;
    logic                  result_valid;

    exp_t        exp_q[$];             // one entry per sampled instruction
    exp_t        exp_cur;              // entry due at the dut output
    bit          checking = 1'b0;
    bit          exp_seen = 1'b0;      // a valid result has been expected
    logic [31:0] lfsr     = 32'hf1d3;
    int          err_count    = 0;
    int          tests_failed = 0;
    int          test_errors [test_count];

    pe_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .din_pe       (din_pe),
        .din_wb       (din_wb),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic step_lfsr();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[62:0], step_lfsr()};
        end
        return v;
    endfunction

    function automatic string test_label(input int idx);
        case (idx)
            0:       return "idle_load";
            1:       return "add_sub_overflow";
            2:       return "mul_low_byte";
            3:       return "imm_forms";
            4:       return "sel_source";
            5:       return "load_alt";
            6:       return "random_stream";
            default: return "flush";
        endcase
    endfunction

    // lane values that wrap on add and on sub
    function automatic logic [31:0] overflow_word(input int n, input bit b_side);
        case (n % 4)
            0:       return b_side ? 32'h01_80_81_ff : 32'hff_80_7f_01;
            1:       return b_side ? 32'h01_ff_01_80 : 32'h00_01_ff_80;
            2:       return b_side ? 32'h01_01_01_01 : 32'hff_ff_ff_ff;
            default: return b_side ? 32'hff_01_80_81 : 32'h01_00_80_7f;
        endcase
    endfunction

    // reference model, straight from the instruction format
    function automatic exp_t expected_lanes(input logic [63:0] ins, input logic [31:0] pe,
                                            input logic [31:0] wb, input int idx);
        exp_t        e;
        logic [2:0]  op;
        logic [31:0] a;
        logic [7:0]  al;
        logic [7:0]  bl;
        logic [7:0]  rl;
        logic [15:0] pl;
        op     = ins[26:24];
        a      = ins[63] ? wb : pe;          // msb picks the source
        e.res  = '0;
        e.valid = (op != 3'b000);
        e.load  = (op[1:0] == 2'b00);
        e.test  = idx;
        for (int i = 0; i < 4; i++) begin
            al = a[8*i +: 8];
            bl = op[2] ? ins[7:0] : ins[31 + 8*i +: 8];  // imm in every lane
            pl = {8'h00, al} * {8'h00, bl};
            case (op[1:0])
                2'b01:   rl = al + bl;       // wraps mod 256
                2'b10:   rl = al - bl;
                2'b11:   rl = pl[7:0];
                default: rl = 8'h00;         // load
            endcase
            e.res[8*i +: 8] = rl;
        end
        return e;
    endfunction

    task automatic drive(input logic [63:0] ins, input logic [31:0] pe,
                         input logic [31:0] wb, input int idx);
        @(negedge clk);
        inst   = ins;
        din_pe = pe;
        din_wb = wb;
        exp_q.push_back(expected_lanes(ins, pe, wb, idx));
    endtask

    task automatic count_error();
        err_count++;
        if (exp_cur.test < test_count) test_errors[exp_cur.test]++;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("mismatch in %s: %s expected %h actual %h",
                 test_label(exp_cur.test), what, want, got);
        count_error();
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic run_test(input int idx);
        logic [63:0] ins;
        logic [63:0] r;
        logic [31:0] pe;
        logic [31:0] wb;
        for (int n = 0; n < burst_len; n++) begin
            ins = rand_bits(64);
            r   = rand_bits(64);
            pe  = r[31:0];
            wb  = r[63:32];
            case (idx)
                0: ins[26:24] = 3'b000;             // no valid ever
                1: begin
                    ins[63]    = 1'b0;              // din_pe as a
                    ins[26:24] = n[2] ? 3'b010 : 3'b001;
                    pe         = overflow_word(n, 1'b0);
                    ins[62:31] = overflow_word(n, 1'b1);
                end
                2: ins[25:24] = 2'b11;              // mul or muli
                3: begin
                    ins[26] = 1'b1;                 // b_word bits left random
                    if (ins[25:24] == 2'b00) ins[25:24] = 2'b01;
                end
                4: begin
                    if (ins[25:24] == 2'b00) ins[25:24] = 2'b10;
                end
                5: ins[25:24] = 2'b00;              // 000 or 100
                default: ;                          // anything goes
            endcase
            drive(ins, pe, wb, idx);
        end
        // drain so this test's results are all checked
        repeat (pe_latency + 1) drive('0, '0, '0, flush_tag);
        @(posedge clk);
    endtask

    ////////////////////
    // checking
    ////////////////////

    // one push per negedge, so the front is the word leaving the lanes
    always @(posedge clk) begin
        if (exp_q.size() >= pe_latency) begin
            exp_cur  = exp_q.pop_front();
            checking = 1'b1;
            if (exp_cur.valid) exp_seen = 1'b1;
        end
    end

    a_valid_match: assert property (
        @(negedge clk) disable iff (!checking)
        result_valid == exp_cur.valid
    ) else report_mismatch("result_valid", {31'd0, exp_cur.valid}, {31'd0, result_valid});

    a_result_match: assert property (
        @(negedge clk) disable iff (!checking)
        result == exp_cur.res
    ) else report_mismatch("result", exp_cur.res, result);

    a_load_zero: assert property (
        @(negedge clk) disable iff (!checking)
        exp_cur.load |-> (result == '0)
    ) else report_mismatch("load result", '0, result);

    a_idle_low: assert property (
        @(negedge clk) disable iff (!checking)
        !exp_seen |-> !result_valid
    ) else begin
        $display("%s: result_valid went high before any nonzero opcode",
                 test_label(exp_cur.test));
        count_error();
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst    = 1'b1;
        inst   = '0;
        din_pe = '0;
        din_wb = '0;
        foreach (test_errors[i]) test_errors[i] = 0;
        repeat (2) @(negedge clk);          // two rising edges in reset
        rst = 1'b0;
        // cleared pipeline plus the idle word sampled at the release edge
        repeat (pe_latency) exp_q.push_back(expected_lanes('0, '0, '0, flush_tag));
        for (int t = 0; t < test_count; t++) begin
            run_test(t);
            if (test_errors[t] == 0) begin
                $display("test %s: pass", test_label(t));
            end else begin
                $display("test %s: fail, %0d errors", test_label(t), test_errors[t]);
                tests_failed++;
            end
        end
        repeat (pe_latency + 1) drive('0, '0, '0, flush_tag);  // last flush checked
        @(posedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 test_count, test_count - tests_failed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== source/lane_ctrl_if.sv ====
`timescale 1ns/1ns

// decoded lane modes, shared by all four lanes
// one value per cycle, lined up with the registered operands
interface lane_ctrl_if;

    logic sub;      // alumode subtract
    logic use_mult; // multiplier in path
    logic zero_out; // opmode zero, lane output forced to 0
    logic valid;    // opcode was nonzero

    // decoder side
    modport decode (
        output sub,
        output use_mult,
        output zero_out,
        output valid
    );

    // lane array side
    modport lanes (
        input sub,
        input use_mult,
        input zero_out,
        input valid
    );

endinterface

// ==== source/pe_decode.sv ====
`timescale 1ns/1ns

module pe_decode (
    input  logic               clk,
    input  logic               rst,
    input  pe_pkg::inst_word_u inst,
    lane_ctrl_if.decode        ctrl
);

    import pe_pkg::*;

    ////////////////////
    // opcode decode
    ////////////////////

    opcode_t opcode;   // same field in both forms
    logic    sub_d;
    logic    mult_d;
    logic    zero_d;
    logic    valid_d;

    assign opcode = inst.reg_form.opcode;

    always_comb begin
        // load modes unless an alu op is seen
        sub_d  = 1'b0;
        mult_d = 1'b0;
        zero_d = 1'b1;
        case (opcode)
            op_add, op_addi: begin
                zero_d = 1'b0;    // plain add
            end
            op_sub, op_subi: begin
                sub_d  = 1'b1;    // a - b
                zero_d = 1'b0;
            end
            op_mul, op_muli: begin
                mult_d = 1'b1;    // low byte of a * b
                zero_d = 1'b0;
            end
            default: begin
                zero_d = 1'b1;    // op_load / op_load_alt
            end
        endcase
    end

    assign valid_d = (opcode != op_load); // load_alt counts as valid

    ////////////////////
    // mode registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.sub      <= 1'b0;
            ctrl.use_mult <= 1'b0;
            ctrl.zero_out <= 1'b1; // idle in load mode
            ctrl.valid    <= 1'b0;
        end else begin
            ctrl.sub      <= sub_d;
            ctrl.use_mult <= mult_d;
            ctrl.zero_out <= zero_d;
            ctrl.valid    <= valid_d;
        end
    end

    // subtract and multiply never share a cycle, the lane has no mul-sub path
    a_no_sub_mult: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.sub && ctrl.use_mult)
    );

endmodule

// ==== source/pe_lane.sv ====
`timescale 1ns/1ns

module pe_lane (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pe_pkg::lane_width-1:0] a,
    input  logic [pe_pkg::lane_width-1:0] b,
    input  logic                          sub,
    input  logic                          use_mult,
    input  logic                          zero_out,
    output logic [pe_pkg::lane_width-1:0] y
);

    import pe_pkg::*;

    ////////////////////
    // stage 1, operands and modes
    ////////////////////

    logic [lane_width-1:0]   a_s1;
    logic [lane_width-1:0]   b_s1;
    logic                    sub_s1;
    logic                    mult_s1;
    logic                    zero_s1;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_s1    <= '0;
            b_s1    <= '0;
            sub_s1  <= 1'b0;
            mult_s1 <= 1'b0;
            zero_s1 <= 1'b0;
        end else begin
            a_s1    <= a;
            b_s1    <= b;
            sub_s1  <= sub;
            mult_s1 <= use_mult;
            zero_s1 <= zero_out;
        end
    end

    ////////////////////
    // stage 2, alu
    ////////////////////

    logic [2*lane_width-1:0] prod;     // full product, low byte kept
    logic [lane_width-1:0]   alu;      // wraps mod 256
    logic [lane_width-1:0]   res_s2;
    logic                    zero_s2;

    assign prod = a_s1 * b_s1;
    assign alu  = mult_s1 ? prod[lane_width-1:0] :
                  sub_s1  ? a_s1 - b_s1 :
                            a_s1 + b_s1;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_s2  <= '0;
            zero_s2 <= 1'b0;
        end else begin
            res_s2  <= alu;
            zero_s2 <= zero_s1;  // follows its data
        end
    end

    ////////////////////
    // stage 3, output
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) y <= '0;
        else     y <= zero_s2 ? '0 : res_s2;  // load clears the lane
    end

    // zero request two stages deep shows up at the output
    a_zero_out: assert property (
        @(posedge clk) disable iff (rst)
        zero_s2 |=> (y == '0)
    );

endmodule

// ==== source/pe_lane_array.sv ====
`timescale 1ns/1ns

module pe_lane_array (
    input  logic                          clk,
    input  logic                          rst,
    lane_ctrl_if.lanes                    ctrl,
    input  logic [pe_pkg::data_width-1:0] a_word,
    input  logic [pe_pkg::data_width-1:0] b_word,
    output logic [pe_pkg::data_width-1:0] result,
    output logic                          result_valid
);

    import pe_pkg::*;

    ////////////////////
    // lanes
    ////////////////////

    // lane 0 on the low byte, no carry between lanes
    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        pe_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .a        (a_word[i*lane_width +: lane_width]),
            .b        (b_word[i*lane_width +: lane_width]),
            .sub      (ctrl.sub),
            .use_mult (ctrl.use_mult),
            .zero_out (ctrl.zero_out),
            .y        (result[i*lane_width +: lane_width])
        );
    end

    ////////////////////
    // valid delay
    ////////////////////

    logic [lane_stages-1:0] valid_sr;  // one bit per lane stage

    always_ff @(posedge clk) begin
        if (rst) valid_sr <= '0;
        else     valid_sr <= {valid_sr[lane_stages-2:0], ctrl.valid};
    end

    assign result_valid = valid_sr[lane_stages-1];  // lines up with lane y

    // nothing left in flight once reset is seen
    a_valid_after_rst: assert property (
        @(posedge clk)
        rst |=> !result_valid
    );

endmodule

// ==== source/pe_operand_stage.sv ====
`timescale 1ns/1ns

module pe_operand_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  pe_pkg::inst_word_u            inst,
    input  logic [pe_pkg::data_width-1:0] din_pe,  // shifted in from neighbour
    input  logic [pe_pkg::data_width-1:0] din_wb,  // memory write back
    output logic [pe_pkg::data_width-1:0] a_word,
    output logic [pe_pkg::data_width-1:0] b_word
);

    import pe_pkg::*;

    ////////////////////
    // field extraction
    ////////////////////

    logic [2:0]            op_bits;   // opcode as raw bits
    logic                  imm_sel;   // immediate form
    logic [data_width-1:0] a_next;
    logic [data_width-1:0] b_next;
    logic [data_width-1:0] imm_word;  // immediate in every byte

    assign op_bits  = inst.reg_form.opcode;
    assign imm_sel  = op_bits[2];
    assign imm_word = {lane_count{inst.imm_form.imm}};

    // msb picks the a source
    assign a_next = inst.reg_form.sel ? din_wb : din_pe;

    // load_alt also lands here, lanes zero it anyway
    assign b_next = imm_sel ? imm_word : inst.reg_form.b_word;

    ////////////////////
    // operand registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            a_word <= '0;
            b_word <= '0;
        end else begin
            a_word <= a_next;  // same edge as decode
            b_word <= b_next;
        end
    end

endmodule

// ==== source/pe_pkg.sv ====
package pe_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int lane_width  = 8;                       // bits per lane
    localparam int lane_count  = 4;                       // lanes per element
    localparam int data_width  = lane_width * lane_count; // 32-bit data word
    localparam int inst_width  = 64;                      // instruction word

    ////////////////////
    // pipeline depth
    ////////////////////

    localparam int lane_stages = 3;               // operand reg, alu reg, output reg
    localparam int pe_latency  = 1 + lane_stages; // decode/operand stage in front

    ////////////////////
    // opcodes
    ////////////////////

    // bit 2 set means immediate form, except for the alternate load
    typedef enum logic [2:0] {
        op_load     = 3'b000, // zero lanes, no valid
        op_add      = 3'b001,
        op_sub      = 3'b010,
        op_mul      = 3'b011,
        op_load_alt = 3'b100, // zero lanes, valid high
        op_addi     = 3'b101,
        op_subi     = 3'b110,
        op_muli     = 3'b111
    } opcode_t;

    ////////////////////
    // instruction word
    ////////////////////

    // register form, one byte per lane from bits 62:31
    typedef struct packed {
        logic             sel;        // 63  a operand source
        logic [31:0]      b_word;     // 62:31
        logic [3:0]       rsvd_hi;    // 30:27
        opcode_t          opcode;     // 26:24
        logic [23:0]      rsvd_lo;    // 23:0
    } inst_reg_t;

    // immediate form, 8-bit immediate broadcast to all lanes
    typedef struct packed {
        logic             sel;        // 63
        logic [35:0]      rsvd_hi;    // 62:27
        opcode_t          opcode;     // 26:24
        logic [15:0]      rsvd_mid;   // 23:8
        logic [7:0]       imm;        // 7:0
    } inst_imm_t;

    // same 64 bits, two decodings
    typedef union packed {
        inst_reg_t reg_form;
        inst_imm_t imm_form;
    } inst_word_u;

endpackage

// ==== source/pe_top.sv ====
`timescale 1ns/1ns

module pe_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pe_pkg::inst_width-1:0] inst,    // raw instruction, decoded as union
    input  logic [pe_pkg::data_width-1:0] din_pe,
    input  logic [pe_pkg::data_width-1:0] din_wb,
    output logic [pe_pkg::data_width-1:0] result,
    output logic                          result_valid
);

    import pe_pkg::*;

    logic [data_width-1:0] a_word;  // registered operand a
    logic [data_width-1:0] b_word;  // registered operand b

    lane_ctrl_if ctrl ();            // decoded modes

    // decode and operand select side by side, one edge each
    pe_decode u_decode (
        .clk  (clk),
        .rst  (rst),
        .inst (inst),
        .ctrl (ctrl)
    );

    pe_operand_stage u_operand (
        .clk    (clk),
        .rst    (rst),
        .inst   (inst),
        .din_pe (din_pe),
        .din_wb (din_wb),
        .a_word (a_word),
        .b_word (b_word)
    );

    // three more edges to the result
    pe_lane_array u_lanes (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .a_word       (a_word),
        .b_word       (b_word),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule
